/* design/comp_engine_pkg.sv */
`default_nettype none

package comp_engine_pkg;

    // bus and compressor widths
    parameter int AHB_DATA_W  = 32;
    parameter int AHB_ADDR_W  = 32;
    parameter int COMP_DATA_W = 64;

    // 16-beat word bursts
    parameter int BEATS_PER_BURST = 16;

    // 128-byte source blocks, 64-byte compressed results
    parameter int RD_BLK_SHIFT = 7;
    parameter int WR_BLK_SHIFT = 6;

    // standard AHB transfer types
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    // two read bursts, compression wait, one write burst
    typedef enum logic [3:0] {
        S_IDLE,
        S_RD1_BUSREQ,
        S_RD1_1ST_ADDR,
        S_RD1_MIDDLE,
        S_RD1_LAST_DATA,
        S_RD2_BUSREQ,
        S_RD2_1ST_ADDR,
        S_RD2_MIDDLE,
        S_RD2_LAST_DATA,
        S_COMP,
        S_WR_BUSREQ,
        S_WR_1ST_ADDR,
        S_WR_MIDDLE,
        S_WR_LAST_DATA
    } eng_state_e;

endpackage

`default_nettype wire

/* design/comp_engine_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module comp_engine_fsm
    import comp_engine_pkg::*;
#(
    parameter int LEN_W = 25
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    input  wire logic [AHB_ADDR_W-1:0]  src_addr_i,
    input  wire logic [AHB_ADDR_W-1:0]  dst_addr_i,
    input  wire logic [LEN_W-1:0]       len_i,
    input  wire logic                   start_i,
    output logic                        done_o,

    input  wire logic                   hgrant_i,
    input  wire logic                   hready_i,
    output logic                        hbusreq_o,
    output logic [AHB_ADDR_W-1:0]       haddr_o,
    output htrans_e                     htrans_o,
    output logic                        hwrite_o,
    output logic [AHB_DATA_W-1:0]       hwdata_o,

    input  wire logic [2:0]             comp_done_i,
    input  wire logic [COMP_DATA_W-1:0] owner_data_i,

    output logic                        beat_en_o,
    output logic [4:0]                  beat_cnt_o,
    output logic                        sel_load_o,
    output logic [2:0]                  buf_addr_o
);

    // beat counter thresholds, second read burst continues at 16
    localparam logic [4:0] RD1_REQ_OFF = 5'(BEATS_PER_BURST - 3);
    localparam logic [4:0] RD1_LAST    = 5'(BEATS_PER_BURST - 2);
    localparam logic [4:0] RD2_REQ_OFF = 5'(2 * BEATS_PER_BURST - 3);
    localparam logic [4:0] RD2_LAST    = 5'(2 * BEATS_PER_BURST - 2);
    localparam logic [4:0] WR_REQ_OFF  = 5'(BEATS_PER_BURST - 2);
    localparam logic [4:0] WR_LAST     = 5'(BEATS_PER_BURST - 1);

    eng_state_e              state, state_n;
    logic [LEN_W-1:0]        blk_cnt, blk_cnt_n;
    logic [LEN_W-1:0]        blk_cnt_inc;
    logic [4:0]              beat_cnt, beat_cnt_n;

    logic                    hbusreq, hbusreq_n;
    logic [AHB_ADDR_W-1:0]   haddr, haddr_n;
    htrans_e                 htrans, htrans_n;
    logic                    hwrite, hwrite_n;
    logic [AHB_DATA_W-1:0]   hwdata, hwdata_n;

    logic [AHB_DATA_W-1:0]   wr_half;

    assign blk_cnt_inc = blk_cnt + 1'b1;

    // even beat carries the upper half of the result word
    assign wr_half = beat_cnt[0] ? owner_data_i[31:0] : owner_data_i[63:32];

    // ------------------------------------------------------------------------
    // next state and bus control
    // ------------------------------------------------------------------------
    always_comb begin
        state_n   = state;
        blk_cnt_n = blk_cnt;
        beat_cnt_n = beat_cnt;
        hbusreq_n = hbusreq;
        haddr_n   = haddr;
        htrans_n  = htrans;
        hwrite_n  = hwrite;
        hwdata_n  = hwdata;
        beat_en_o = 1'b0;
        sel_load_o = 1'b0;

        case (state)
            S_IDLE: begin
                if (start_i && (len_i != '0)) begin
                    blk_cnt_n = '0;
                    hbusreq_n = 1'b1;
                    state_n   = S_RD1_BUSREQ;
                end
            end
            S_RD1_BUSREQ: begin
                if (hgrant_i) begin
                    haddr_n  = src_addr_i + (AHB_ADDR_W'(blk_cnt) << RD_BLK_SHIFT);
                    htrans_n = HTRANS_NONSEQ;
                    hwrite_n = 1'b0;
                    state_n  = S_RD1_1ST_ADDR;
                end
            end
            S_RD1_1ST_ADDR: begin
                if (hready_i) begin
                    haddr_n    = haddr + 'd4;
                    htrans_n   = HTRANS_SEQ;
                    // reads count data phases
                    beat_cnt_n = '0;
                    state_n    = S_RD1_MIDDLE;
                end
            end
            S_RD1_MIDDLE: begin
                if (hready_i) begin
                    haddr_n    = haddr + 'd4;
                    beat_en_o  = 1'b1;
                    beat_cnt_n = beat_cnt + 1'b1;
                    if (beat_cnt == RD1_REQ_OFF) begin
                        hbusreq_n = 1'b0;
                    end
                    if (beat_cnt == RD1_LAST) begin
                        htrans_n = HTRANS_IDLE;
                        state_n  = S_RD1_LAST_DATA;
                    end
                end
            end
            S_RD1_LAST_DATA: begin
                if (hready_i) begin
                    beat_en_o  = 1'b1;
                    beat_cnt_n = beat_cnt + 1'b1;
                    hbusreq_n  = 1'b1;
                    state_n    = S_RD2_BUSREQ;
                end
            end
            S_RD2_BUSREQ: begin
                // address already sits at the second half of the block
                if (hgrant_i) begin
                    htrans_n = HTRANS_NONSEQ;
                    state_n  = S_RD2_1ST_ADDR;
                end
            end
            S_RD2_1ST_ADDR: begin
                if (hready_i) begin
                    haddr_n  = haddr + 'd4;
                    htrans_n = HTRANS_SEQ;
                    state_n  = S_RD2_MIDDLE;
                end
            end
            S_RD2_MIDDLE: begin
                if (hready_i) begin
                    haddr_n    = haddr + 'd4;
                    beat_en_o  = 1'b1;
                    beat_cnt_n = beat_cnt + 1'b1;
                    if (beat_cnt == RD2_REQ_OFF) begin
                        hbusreq_n = 1'b0;
                    end
                    if (beat_cnt == RD2_LAST) begin
                        htrans_n = HTRANS_IDLE;
                        state_n  = S_RD2_LAST_DATA;
                    end
                end
            end
            S_RD2_LAST_DATA: begin
                if (hready_i) begin
                    beat_en_o  = 1'b1;
                    beat_cnt_n = beat_cnt + 1'b1;
                    state_n    = S_COMP;
                end
            end
            S_COMP: begin
                if (&comp_done_i) begin
                    sel_load_o = 1'b1;
                    hbusreq_n  = 1'b1;
                    state_n    = S_WR_BUSREQ;
                end
            end
            S_WR_BUSREQ: begin
                if (hgrant_i) begin
                    haddr_n    = dst_addr_i + (AHB_ADDR_W'(blk_cnt) << WR_BLK_SHIFT);
                    htrans_n   = HTRANS_NONSEQ;
                    hwrite_n   = 1'b1;
                    // writes count address phases
                    beat_cnt_n = '0;
                    state_n    = S_WR_1ST_ADDR;
                end
            end
            S_WR_1ST_ADDR: begin
                if (hready_i) begin
                    haddr_n    = haddr + 'd4;
                    htrans_n   = HTRANS_SEQ;
                    beat_cnt_n = beat_cnt + 1'b1;
                    hwdata_n   = wr_half;
                    state_n    = S_WR_MIDDLE;
                end
            end
            S_WR_MIDDLE: begin
                if (hready_i) begin
                    haddr_n    = haddr + 'd4;
                    beat_cnt_n = beat_cnt + 1'b1;
                    hwdata_n   = wr_half;
                    if (beat_cnt == WR_REQ_OFF) begin
                        hbusreq_n = 1'b0;
                    end
                    if (beat_cnt == WR_LAST) begin
                        htrans_n = HTRANS_IDLE;
                        state_n  = S_WR_LAST_DATA;
                    end
                end
            end
            S_WR_LAST_DATA: begin
                if (hready_i) begin
                    blk_cnt_n = blk_cnt_inc;
                    if (blk_cnt_inc == len_i) begin
                        state_n = S_IDLE;
                    end else begin
                        hbusreq_n = 1'b1;
                        state_n   = S_RD1_BUSREQ;
                    end
                end
            end
            default: begin
                state_n = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            blk_cnt  <= '0;
            beat_cnt <= '0;
            hbusreq  <= 1'b0;
            htrans   <= HTRANS_IDLE;
            hwrite   <= 1'b0;
        end else begin
            state    <= state_n;
            blk_cnt  <= blk_cnt_n;
            beat_cnt <= beat_cnt_n;
            hbusreq  <= hbusreq_n;
            htrans   <= htrans_n;
            hwrite   <= hwrite_n;
        end
    end

    // address and write data payload
    always_ff @(posedge clk) begin
        haddr  <= haddr_n;
        hwdata <= hwdata_n;
    end

    // ------------------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------------------
    // low while a start is presented so a status poll never sees stale done
    assign done_o = (state == S_IDLE) && !start_i;

    assign hbusreq_o  = hbusreq;
    assign haddr_o    = haddr;
    assign htrans_o   = htrans;
    assign hwrite_o   = hwrite;
    assign hwdata_o   = hwdata;
    assign beat_cnt_o = beat_cnt;
    assign buf_addr_o = beat_cnt[3:1];

endmodule

`default_nettype wire

/* design/rd_beat_packer.sv */
`timescale 1ns/10ps
`default_nettype none

module rd_beat_packer
    import comp_engine_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    input  wire logic                  beat_en_i,
    input  wire logic [4:0]            beat_cnt_i,
    input  wire logic [AHB_DATA_W-1:0] hrdata_i,

    output logic                       comp_wren_o,
    output logic                       comp_sop_o,
    output logic                       comp_eop_o,
    output logic [COMP_DATA_W-1:0]     comp_wdata_o
);

    logic                   odd_beat;
    logic [3:0]             pair_idx;
    logic [COMP_DATA_W-1:0] wdata;

    assign odd_beat = beat_cnt_i[0];

    // word index within the block
    assign pair_idx = beat_cnt_i[4:1];

    // ------------------------------------------------------------------------
    // strobes, one cycle after the odd beat
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            comp_wren_o <= 1'b0;
            comp_sop_o  <= 1'b0;
            comp_eop_o  <= 1'b0;
        end else begin
            comp_wren_o <= beat_en_i && odd_beat;
            comp_sop_o  <= beat_en_i && odd_beat && (pair_idx == 4'd0);
            comp_eop_o  <= beat_en_i && odd_beat && (pair_idx == 4'hf);
        end
    end

    // even beat fills the upper half, odd beat the lower half
    always_ff @(posedge clk) begin
        if (beat_en_i) begin
            if (odd_beat) begin
                wdata[31:0] <= hrdata_i;
            end else begin
                wdata[63:32] <= hrdata_i;
            end
        end
    end

    assign comp_wdata_o = wdata;

endmodule

`default_nettype wire

/* design/comp_result_select.sv */
`timescale 1ns/10ps
`default_nettype none

module comp_result_select
    import comp_engine_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    input  wire logic                   sel_load_i,
    input  wire logic [2:0]             comp_fail_i,

    input  wire logic [COMP_DATA_W-1:0] comp0_rdata_i,
    input  wire logic [COMP_DATA_W-1:0] comp1_rdata_i,
    input  wire logic [COMP_DATA_W-1:0] comp2_rdata_i,

    output logic [COMP_DATA_W-1:0]      owner_data_o
);

    logic [1:0] owner;
    logic [1:0] winner;

    // first compressor that did not fail, 0 when all failed
    always_comb begin
        if (!comp_fail_i[0]) begin
            winner = 2'd0;
        end else if (!comp_fail_i[1]) begin
            winner = 2'd1;
        end else if (!comp_fail_i[2]) begin
            winner = 2'd2;
        end else begin
            winner = 2'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner <= 2'd0;
        end else if (sel_load_i) begin
            owner <= winner;
        end
    end

    // buffers answer combinationally at buf_addr
    always_comb begin
        case (owner)
            2'd1:    owner_data_o = comp1_rdata_i;
            2'd2:    owner_data_o = comp2_rdata_i;
            default: owner_data_o = comp0_rdata_i;
        endcase
    end

endmodule

`default_nettype wire

/* design/comp_engine_top.sv */
`timescale 1ns/10ps
`default_nettype none

module comp_engine_top
    import comp_engine_pkg::*;
#(
    parameter int LEN_W = 25
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    // job control
    input  wire logic [AHB_ADDR_W-1:0]  src_addr_i,
    input  wire logic [AHB_ADDR_W-1:0]  dst_addr_i,
    input  wire logic [LEN_W-1:0]       len_i,
    input  wire logic                   start_i,
    output logic                        done_o,

    // AHB master
    input  wire logic                   hgrant_i,
    input  wire logic                   hready_i,
    input  wire logic [AHB_DATA_W-1:0]  hrdata_i,
    output logic                        hbusreq_o,
    output logic [AHB_ADDR_W-1:0]       haddr_o,
    output htrans_e                     htrans_o,
    output logic                        hwrite_o,
    output logic [AHB_DATA_W-1:0]       hwdata_o,

    // compressor stream and status
    output logic                        comp_wren_o,
    output logic                        comp_sop_o,
    output logic                        comp_eop_o,
    output logic [COMP_DATA_W-1:0]      comp_wdata_o,
    input  wire logic [2:0]             comp_done_i,
    input  wire logic [2:0]             comp_fail_i,

    // result buffers
    output logic [2:0]                  buf_addr_o,
    input  wire logic [COMP_DATA_W-1:0] comp0_rdata_i,
    input  wire logic [COMP_DATA_W-1:0] comp1_rdata_i,
    input  wire logic [COMP_DATA_W-1:0] comp2_rdata_i
);

    logic                   beat_en;
    logic [4:0]             beat_cnt;
    logic                   sel_load;
    logic [COMP_DATA_W-1:0] owner_data;

    comp_engine_fsm #(
        .LEN_W (LEN_W)
    ) i_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .src_addr_i   (src_addr_i),
        .dst_addr_i   (dst_addr_i),
        .len_i        (len_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .hgrant_i     (hgrant_i),
        .hready_i     (hready_i),
        .hbusreq_o    (hbusreq_o),
        .haddr_o      (haddr_o),
        .htrans_o     (htrans_o),
        .hwrite_o     (hwrite_o),
        .hwdata_o     (hwdata_o),
        .comp_done_i  (comp_done_i),
        .owner_data_i (owner_data),
        .beat_en_o    (beat_en),
        .beat_cnt_o   (beat_cnt),
        .sel_load_o   (sel_load),
        .buf_addr_o   (buf_addr_o)
    );

    rd_beat_packer i_packer (
        .clk          (clk),
        .rst_n        (rst_n),
        .beat_en_i    (beat_en),
        .beat_cnt_i   (beat_cnt),
        .hrdata_i     (hrdata_i),
        .comp_wren_o  (comp_wren_o),
        .comp_sop_o   (comp_sop_o),
        .comp_eop_o   (comp_eop_o),
        .comp_wdata_o (comp_wdata_o)
    );

    comp_result_select i_select (
        .clk           (clk),
        .rst_n         (rst_n),
        .sel_load_i    (sel_load),
        .comp_fail_i   (comp_fail_i),
        .comp0_rdata_i (comp0_rdata_i),
        .comp1_rdata_i (comp1_rdata_i),
        .comp2_rdata_i (comp2_rdata_i),
        .owner_data_o  (owner_data)
    );

endmodule

`default_nettype wire

/* test/ahb_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module ahb_mem_model
    import comp_engine_pkg::*;
#(
    parameter int GNT_DLY = 3
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  rand_wait_i,
    input  wire logic                  hbusreq_i,
    input  wire logic [AHB_ADDR_W-1:0] haddr_i,
    input  wire htrans_e               htrans_i,
    input  wire logic                  hwrite_i,
    input  wire logic [AHB_DATA_W-1:0] hwdata_i,
    output logic                       hgrant_o,
    output logic                       hready_o,
    output logic [AHB_DATA_W-1:0]      hrdata_o
);

    logic [31:0]           mem [0:1023];
    logic [AHB_ADDR_W-1:0] log_addr [$];
    logic                  log_write [$];

    integer                seed;
    int                    gnt_cnt;
    logic                  dp_valid;
    logic                  dp_write;
    logic [AHB_ADDR_W-1:0] dp_addr;

    // fill word depends on the whole byte address
    initial begin
        seed = 64520;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'(i * 4) ^ 32'h5a00_0000 ^ (32'(i) << 20);
        end
    end

    // data phase read of the pending address
    assign hrdata_o = mem[dp_addr[11:2]];

    always @(posedge clk) begin
        if (!rst_n) begin
            hready_o <= 1'b1;
            hgrant_o <= 1'b0;
            gnt_cnt  <= 0;
            dp_valid <= 1'b0;
            dp_write <= 1'b0;
            dp_addr  <= '0;
        end else begin
            // grant a few cycles after request
            if (hbusreq_i) begin
                if (gnt_cnt != GNT_DLY) begin
                    gnt_cnt <= gnt_cnt + 1;
                end
                hgrant_o <= (gnt_cnt == GNT_DLY);
            end else begin
                gnt_cnt  <= 0;
                hgrant_o <= 1'b0;
            end
            if (hready_o) begin
                if (dp_valid && dp_write) begin
                    mem[dp_addr[11:2]] <= hwdata_i;
                end
                dp_valid <= (htrans_i == HTRANS_NONSEQ) || (htrans_i == HTRANS_SEQ);
                dp_addr  <= haddr_i;
                dp_write <= hwrite_i;
                if (htrans_i == HTRANS_NONSEQ) begin
                    log_addr.push_back(haddr_i);
                    log_write.push_back(hwrite_i);
                end
            end
            hready_o <= rand_wait_i ? (($random(seed) & 3) != 0) : 1'b1;
        end
    end

endmodule

`default_nettype wire

/* test/comp_engine_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module comp_engine_assert
    import comp_engine_pkg::*;
(
    input wire logic                  clk,
    input wire logic                  rst_n,
    input wire logic                  comp_wren_o,
    input wire logic                  comp_sop_o,
    input wire logic                  comp_eop_o,
    input wire htrans_e               htrans_o,
    input wire logic [AHB_ADDR_W-1:0] haddr_o,
    input wire logic                  hready_i,
    input wire logic                  hwrite_o
);

    // failed assertions so far
    int fail_cnt = 0;

    // markers only travel with a word
    assert property (@(posedge clk) disable iff (!rst_n)
        (comp_sop_o || comp_eop_o) |-> comp_wren_o)
        else begin
            $error("sop or eop without wren");
            fail_cnt++;
        end

    // incrementing burst address
    assert property (@(posedge clk) disable iff (!rst_n)
        ((htrans_o == HTRANS_SEQ)
            && $past((htrans_o == HTRANS_NONSEQ || htrans_o == HTRANS_SEQ) && hready_i))
        |-> (haddr_o == $past(haddr_o) + 32'd4))
        else begin
            $error("burst address did not advance by 4");
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        (htrans_o == HTRANS_SEQ) |-> (hwrite_o == $past(hwrite_o)))
        else begin
            $error("hwrite changed inside a burst");
            fail_cnt++;
        end

endmodule

`default_nettype wire

/* test/comp_engine_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module comp_engine_tb;
    import comp_engine_pkg::*;

    localparam logic [31:0] SRC = 32'h100;
    localparam logic [31:0] DST = 32'h800;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic [31:0] src_addr = '0;
    logic [31:0] dst_addr = '0;
    logic [24:0] len = '0;
    logic start = 1'b0;
    logic done;
    logic hgrant, hready, hbusreq, hwrite, rand_wait = 1'b0;
    logic [31:0] hrdata, haddr, hwdata;
    htrans_e htrans;
    logic comp_wren, comp_sop, comp_eop;
    logic [63:0] comp_wdata, rdata0, rdata1, rdata2;
    logic [2:0] comp_done = '0;
    logic [2:0] comp_fail = '0;
    logic [2:0] buf_addr;
    logic [63:0] cap_data [$];
    logic cap_sop [$];
    logic cap_eop [$];
    int done_dly = 0;
    int n_checks = 0;
    int n_errors = 0;

    always #20 clk = ~clk;

    comp_engine_top #(.LEN_W(25)) i_dut (
        .clk(clk), .rst_n(rst_n), .src_addr_i(src_addr), .dst_addr_i(dst_addr),
        .len_i(len), .start_i(start), .done_o(done), .hgrant_i(hgrant),
        .hready_i(hready), .hrdata_i(hrdata), .hbusreq_o(hbusreq), .haddr_o(haddr),
        .htrans_o(htrans), .hwrite_o(hwrite), .hwdata_o(hwdata),
        .comp_wren_o(comp_wren), .comp_sop_o(comp_sop), .comp_eop_o(comp_eop),
        .comp_wdata_o(comp_wdata), .comp_done_i(comp_done), .comp_fail_i(comp_fail),
        .buf_addr_o(buf_addr), .comp0_rdata_i(rdata0), .comp1_rdata_i(rdata1),
        .comp2_rdata_i(rdata2)
    );

    ahb_mem_model i_mem (
        .clk(clk), .rst_n(rst_n), .rand_wait_i(rand_wait), .hbusreq_i(hbusreq),
        .haddr_i(haddr), .htrans_i(htrans), .hwrite_i(hwrite), .hwdata_i(hwdata),
        .hgrant_o(hgrant), .hready_o(hready), .hrdata_o(hrdata)
    );

    bind comp_engine_top comp_engine_assert i_assert (
        .clk(clk), .rst_n(rst_n), .comp_wren_o(comp_wren_o), .comp_sop_o(comp_sop_o),
        .comp_eop_o(comp_eop_o), .htrans_o(htrans_o), .haddr_o(haddr_o),
        .hready_i(hready_i), .hwrite_o(hwrite_o)
    );

    // source pattern, same rule as the memory fill
    function automatic logic [31:0] src_word(input logic [31:0] a);
        return a ^ 32'h5a00_0000 ^ ((a >> 2) << 20);
    endfunction

    // result buffer word of compressor n at address a
    function automatic logic [63:0] buf_word(input int n, input logic [2:0] a);
        return {4'hc, 4'(n), 5'h0, a, 16'h7e00 ^ 16'(a * 3), 16'(n * 256 + a), 16'h2468};
    endfunction

    assign rdata0 = buf_word(0, buf_addr);
    assign rdata1 = buf_word(1, buf_addr);
    assign rdata2 = buf_word(2, buf_addr);

    // ------------------------------------------------------------------------
    // compressor model
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            comp_done <= '0;
            done_dly  <= 0;
        end else begin
            if (comp_wren) begin
                cap_data.push_back(comp_wdata);
                cap_sop.push_back(comp_sop);
                cap_eop.push_back(comp_eop);
            end
            if (comp_wren && comp_sop) begin
                comp_done <= '0;
            end else if (comp_wren && comp_eop) begin
                done_dly <= 4;
            end else if (done_dly > 1) begin
                done_dly <= done_dly - 1;
            end else if (done_dly == 1) begin
                comp_done <= 3'b111;
                done_dly  <= 0;
            end
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic run_job(input logic [31:0] src, input logic [31:0] dst,
                           input logic [24:0] n_blk);
        int cnt;
        @(posedge clk);
        src_addr <= src;
        dst_addr <= dst;
        len      <= n_blk;
        start    <= 1'b1;
        @(negedge clk);
        check_value("done_o during start", done, 0);
        @(posedge clk);
        start <= 1'b0;
        cnt = 0;
        @(negedge clk);
        while (!done && cnt < 20000) begin
            @(negedge clk);
            cnt++;
        end
        if (!done) begin
            n_errors++;
            $display("timeout: done_o did not return high after a start");
        end
    endtask

    task automatic check_dst(input logic [31:0] dst, input int b, input int owner);
        logic [31:0] a;
        logic [63:0] w;
        for (int j = 0; j < 8; j++) begin
            a = dst + 32'(64 * b + 8 * j);
            w = buf_word(owner, 3'(j));
            check_value("dst upper", i_mem.mem[a[11:2]], w[63:32]);
            check_value("dst lower", i_mem.mem[(a + 4) >> 2 & 1023], w[31:0]);
        end
    endtask

    task automatic report(input string name, input int err0);
        $display("%s finished with %0d errors", name, n_errors - err0);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic test_stream();
        int err0 = n_errors;
        cap_data.delete();
        cap_sop.delete();
        cap_eop.delete();
        @(posedge clk);
        comp_fail <= 3'b000;
        run_job(SRC, DST, 1);
        check_value("word count", cap_data.size(), 16);
        for (int k = 0; k < 16 && k < cap_data.size(); k++) begin
            check_value("comp_wdata", cap_data[k],
                {src_word(SRC + 32'(8 * k)), src_word(SRC + 32'(8 * k + 4))});
            check_value("comp_sop", cap_sop[k], k == 0);
            check_value("comp_eop", cap_eop[k], k == 15);
        end
        report("stream", err0);
    endtask

    task automatic test_writeback();
        int err0 = n_errors;
        @(posedge clk);
        comp_fail <= 3'b000;
        run_job(SRC, DST + 32'h40, 1);
        check_dst(DST + 32'h40, 0, 0);
        @(negedge clk);
        check_value("done_o", done, 1);
        report("writeback", err0);
    endtask

    task automatic test_priority();
        int err0 = n_errors;
        @(posedge clk);
        comp_fail <= 3'b001;
        run_job(SRC, DST + 32'h80, 1);
        check_dst(DST + 32'h80, 0, 1);
        @(posedge clk);
        comp_fail <= 3'b011;
        run_job(SRC, DST + 32'hc0, 1);
        check_dst(DST + 32'hc0, 0, 2);
        @(posedge clk);
        comp_fail <= 3'b111;
        run_job(SRC, DST + 32'h100, 1);
        check_dst(DST + 32'h100, 0, 0);
        report("priority", err0);
    endtask

    task automatic test_multi();
        int err0 = n_errors;
        @(posedge clk);
        comp_fail <= 3'b000;
        rand_wait <= 1'b1;
        i_mem.log_addr.delete();
        i_mem.log_write.delete();
        run_job(SRC, DST + 32'h140, 3);
        check_value("burst count", i_mem.log_addr.size(), 9);
        for (int b = 0; b < 3 && i_mem.log_addr.size() == 9; b++) begin
            check_value("rd1 haddr", i_mem.log_addr[3 * b], SRC + 32'(128 * b));
            check_value("rd1 hwrite", i_mem.log_write[3 * b], 0);
            check_value("rd2 haddr", i_mem.log_addr[3 * b + 1], SRC + 32'(128 * b + 64));
            check_value("rd2 hwrite", i_mem.log_write[3 * b + 1], 0);
            check_value("wr haddr", i_mem.log_addr[3 * b + 2],
                DST + 32'h140 + 32'(64 * b));
            check_value("wr hwrite", i_mem.log_write[3 * b + 2], 1);
            check_dst(DST + 32'h140, b, 0);
        end
        rand_wait <= 1'b0;
        report("multi block", err0);
    endtask

    task automatic test_zero();
        int err0 = n_errors;
        run_job(SRC, DST, 0);
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_value("hbusreq_o", hbusreq, 0);
            check_value("done_o", done, 1);
        end
        report("zero length", err0);
    endtask

    initial begin
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_stream();
        test_writeback();
        test_priority();
        test_multi();
        test_zero();
        n_errors += i_dut.i_assert.fail_cnt;
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
design/comp_engine_pkg.sv
design/comp_engine_fsm.sv
design/rd_beat_packer.sv
design/comp_result_select.sv
design/comp_engine_top.sv
test/ahb_mem_model.sv
test/comp_engine_assert.sv
test/comp_engine_tb.sv

/* run.sh */
#!/bin/bash
# build and run with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module comp_engine_tb -o comp_engine_sim > build.log 2>&1 \
    && ./obj_dir/comp_engine_sim > sim.log 2>&1 \
    || { echo "build or simulation error"; exit 1; }
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
